// ==== project.f ====
source/cache_pkg.sv
source/mem_if.sv
source/cache_arrays.sv
source/cache_ctrl.sv
source/main_memory.sv
source/cache_top.sv
bench/cache_props.sv
bench/cache_tb.sv

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

    localparam int READY_TIMEOUT = 200;
    localparam int DONE_TIMEOUT  = 200;
    localparam int NUM_RANDOM    = 400;
    localparam int SHADOW_WORDS  = 64;
    localparam int NUM_ROUNDS    = 6;

    logic                          clk;
    logic                          reset_n;
    logic                          i_read;
    logic                          i_write;
    logic [cache_pkg::ADDR_W-1:0]  i_addr;
    logic [cache_pkg::WORD_W-1:0]  i_wdata;
    logic                          o_ready;
    logic                          o_done;
    logic                          o_hit;
    logic [cache_pkg::WORD_W-1:0]  o_rdata;

    // Reference model of memory contents and cache tag state
    logic [cache_pkg::WORD_W-1:0]  shadow      [SHADOW_WORDS];
    logic                          model_valid [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::TAG_W-1:0]   model_tag   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic                          model_lru   [cache_pkg::NUM_SETS];
    logic [31:0]                   rng_state;

    cache_top cache_top_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .i_read  (i_read),
        .i_write (i_write),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .o_ready (o_ready),
        .o_done  (o_done),
        .o_hit   (o_hit),
        .o_rdata (o_rdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Way whose valid tag matches, or -1 on a miss
    function automatic int find_way(logic [cache_pkg::ADDR_W-1:0] addr);
        logic                        s;
        logic [cache_pkg::TAG_W-1:0] t;
        int                          way;
        s   = addr[2];
        t   = addr[15:3];
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[s][w] && (model_tag[s][w] == t)) begin
                way = w;
            end
        end
        return way;
    endfunction

    // First line of the set, inside the 64-word window, that the model does not hold
    function automatic logic [cache_pkg::ADDR_W-1:0] uncached_addr(logic s);
        logic [cache_pkg::ADDR_W-1:0] cand;
        logic [cache_pkg::ADDR_W-1:0] found;
        found = '0;
        for (int t = 7; t >= 0; t--) begin
            cand = {10'b0, t[2:0], s, 2'b00};
            if (find_way(cand) < 0) begin
                found = cand;
            end
        end
        return found;
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic compare_values(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected %0h actual %0h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Simulation stopped at the first mismatch");
        end
    endtask

    task automatic update_model(bit is_write, logic [15:0] addr, logic [15:0] wdata, int way);
        logic s;
        logic v;
        s = addr[2];
        if (is_write) begin
            shadow[addr[5:0]] = wdata;
            // Write hit touches LRU and write miss does not allocate
            if (way >= 0) begin
                model_lru[s] = (way == 0);
            end
        end else if (way < 0) begin
            if (!model_valid[s][0]) begin
                v = 1'b0;
            end else if (!model_valid[s][1]) begin
                v = 1'b1;
            end else begin
                v = model_lru[s];
            end
            model_valid[s][v] = 1'b1;
            model_tag[s][v]   = addr[15:3];
            model_lru[s]      = !v;
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (o_ready !== 1'b1) begin
            if (waited >= READY_TIMEOUT) abort_run("Timed out waiting for o_ready");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic run_request(bit is_write, logic [15:0] addr, logic [15:0] wdata, string test);
        int          way;
        int          cycles;
        logic [15:0] exp_data;
        string       name;
        wait_ready();
        way      = find_way(addr);
        exp_data = shadow[addr[5:0]];
        name     = $sformatf("%s %s @%0h", test, is_write ? "write" : "read", addr);
        i_read   = !is_write;
        i_write  = is_write;
        i_addr   = addr;
        i_wdata  = wdata;
        @(negedge clk);
        i_read  = 1'b0;
        i_write = 1'b0;
        cycles  = 1;
        compare_values({name, " ready after accept"}, 0, o_ready);
        while (o_done !== 1'b1) begin
            if (cycles >= DONE_TIMEOUT) abort_run("Timed out waiting for o_done");
            @(negedge clk);
            cycles++;
        end
        compare_values({name, " hit"}, (way >= 0), o_hit);
        if (!is_write) begin
            compare_values({name, " data"}, exp_data, o_rdata);
            if (way >= 0) compare_values({name, " hit latency"}, 2, cycles);
        end
        update_model(is_write, addr, wdata, way);
    endtask

    task automatic evict_line(logic [15:0] addr, string test);
        for (int n = 0; n < 4; n++) begin
            if (find_way(addr) >= 0) run_request(1'b0, uncached_addr(addr[2]), '0, test);
        end
        if (find_way(addr) >= 0) abort_run("Could not evict a line from the cache");
    endtask

    initial begin
        logic [15:0] addr;
        logic [15:0] data;
        clk       = 1'b0;
        reset_n   = 1'b0;
        i_read    = 1'b0;
        i_write   = 1'b0;
        i_addr    = '0;
        i_wdata   = '0;
        rng_state = 32'h200ef03f;
        for (int s = 0; s < 2; s++) begin
            model_lru[s] = 1'b0;
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        compare_values("reset o_ready", 1, o_ready);
        compare_values("reset o_done", 0, o_done);

        // Fill memory through the cache, then read it back
        for (int a = 0; a < SHADOW_WORDS; a++) begin
            rng_state = xorshift32(rng_state);
            run_request(1'b1, 16'(a), rng_state[15:0], "init");
        end
        for (int a = 0; a < SHADOW_WORDS; a++) begin
            run_request(1'b0, 16'(a), '0, "init");
        end

        // Half the traffic in the first 16 words, which fit the cache
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng_state = xorshift32(rng_state);
            addr = {10'b0, rng_state[30] ? rng_state[21:20] : 2'b00, rng_state[19:16]};
            run_request(rng_state[31], addr, rng_state[15:0], "random");
        end

        // Aliased write above the memory depth
        for (int n = 0; n < NUM_ROUNDS; n++) begin
            rng_state = xorshift32(rng_state);
            addr = {10'b0, rng_state[21:16]};
            evict_line(addr, "wrap");
            run_request(1'b1, addr + 16'(cache_pkg::MEM_WORDS), rng_state[15:0], "wrap");
            run_request(1'b0, addr, '0, "wrap");
            run_request(1'b0, addr, '0, "wrap refill");
        end

        // Requests right behind a write hit with its line write in flight
        for (int n = 0; n < NUM_ROUNDS; n++) begin
            rng_state = xorshift32(rng_state);
            addr = {10'b0, rng_state[21:16]};
            data = rng_state[15:0];
            run_request(1'b0, addr, '0, "overlap");
            run_request(1'b1, addr, data, "overlap");
            run_request(1'b0, addr ^ 16'd1, '0, "overlap");
            run_request(1'b0, addr, '0, "overlap");
            run_request(1'b1, addr, ~data, "overlap miss");
            run_request(1'b0, uncached_addr(addr[2]), '0, "overlap miss");
            evict_line(addr, "overlap miss");
            run_request(1'b0, addr, '0, "overlap miss");
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== bench/cache_props.sv ====
`timescale 1ns/1ps

module cache_props (
    input logic clk,
    input logic reset_n,
    input logic i_read,
    input logic i_write,
    input logic i_ready,
    input logic i_done,
    input logic i_mem_rd,
    input logic i_mem_wr,
    input logic i_mem_ack
);

    // Memory request issued and not yet acknowledged
    logic mem_busy_q;
    // Processor request accepted and not yet completed
    logic req_open_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mem_busy_q <= 1'b0;
            req_open_q <= 1'b0;
        end else begin
            if (i_mem_rd || i_mem_wr) begin
                mem_busy_q <= 1'b1;
            end else if (i_mem_ack) begin
                mem_busy_q <= 1'b0;
            end
            // A new request can be accepted in the cycle of o_done
            if (i_ready && (i_read || i_write)) begin
                req_open_q <= 1'b1;
            end else if (i_done) begin
                req_open_q <= 1'b0;
            end
        end
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(i_mem_rd && i_mem_wr))
        else $error("Memory read and write strobes are high together");

    one_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
        (i_mem_rd || i_mem_wr) |-> !mem_busy_q)
        else $error("Memory request issued while another one is outstanding");

    done_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        i_done |=> !i_done)
        else $error("o_done is high for more than one cycle");

    ready_low_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (req_open_q && !i_done) |-> !i_ready)
        else $error("o_ready is high before the accepted request completed");

endmodule

bind cache_ctrl cache_props cache_props_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_read    (i_read),
    .i_write   (i_write),
    .i_ready   (o_ready),
    .i_done    (o_done),
    .i_mem_rd  (mem.rd),
    .i_mem_wr  (mem.wr),
    .i_mem_ack (mem.ack)
);

// ==== source/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_read,
    input  logic                          i_write,
    input  logic [cache_pkg::ADDR_W-1:0]  i_addr,
    input  logic [cache_pkg::WORD_W-1:0]  i_wdata,
    output logic                          o_ready,
    output logic                          o_done,
    output logic                          o_hit,
    output logic [cache_pkg::WORD_W-1:0]  o_rdata
);

    mem_if mem_bus ();

    // Controller to arrays
    logic [cache_pkg::ADDR_W-1:0]   lookup_addr;
    logic                           hit;
    logic                           hit_way;
    logic [cache_pkg::LINE_W-1:0]   hit_line;
    logic                           victim_way;
    logic                           fill;
    logic                           fill_way;
    logic [cache_pkg::TAG_W-1:0]    fill_tag;
    logic [cache_pkg::LINE_W-1:0]   fill_line;
    logic                           upd;
    logic                           upd_way;
    logic [cache_pkg::OFF_W-1:0]    upd_off;
    logic [cache_pkg::WORD_W-1:0]   upd_word;

    cache_ctrl cache_ctrl_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_ready       (o_ready),
        .o_done        (o_done),
        .o_hit         (o_hit),
        .o_rdata       (o_rdata),
        .mem           (mem_bus),
        .o_lookup_addr (lookup_addr),
        .i_hit         (hit),
        .i_hit_way     (hit_way),
        .i_hit_line    (hit_line),
        .i_victim_way  (victim_way),
        .o_fill        (fill),
        .o_fill_way    (fill_way),
        .o_fill_tag    (fill_tag),
        .o_fill_line   (fill_line),
        .o_upd         (upd),
        .o_upd_way     (upd_way),
        .o_upd_off     (upd_off),
        .o_upd_word    (upd_word)
    );

    cache_arrays cache_arrays_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_lookup_addr (lookup_addr),
        .i_fill        (fill),
        .i_fill_way    (fill_way),
        .i_fill_tag    (fill_tag),
        .i_fill_line   (fill_line),
        .i_upd         (upd),
        .i_upd_way     (upd_way),
        .i_upd_off     (upd_off),
        .i_upd_word    (upd_word),
        .o_hit         (hit),
        .o_hit_way     (hit_way),
        .o_hit_line    (hit_line),
        .o_victim_way  (victim_way)
    );

    main_memory main_memory_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .mem     (mem_bus)
    );

endmodule

// ==== source/main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
    input  logic clk,
    input  logic reset_n,
    mem_if.mem   mem
);

    logic [cache_pkg::WORD_W-1:0]   mem_q [cache_pkg::MEM_WORDS];

    // Access in progress
    logic                           busy_q;
    logic [cache_pkg::LAT_W-1:0]    cnt_q;
    logic                           ack;

    // Request captured when it was strobed
    logic [cache_pkg::ADDR_W-1:0]   addr_q;
    cache_pkg::mem_size_e           size_q;
    logic                           wr_q;
    logic [cache_pkg::LINE_W-1:0]   wdata_q;

    logic                           start;
    logic [cache_pkg::MEM_AW-1:0]   word_idx;

    assign start    = (mem.rd || mem.wr) && !busy_q;
    assign ack      = busy_q && (cnt_q == '0);
    assign mem.ack  = ack;

    // Addresses wrap modulo the memory depth
    assign word_idx = addr_q[cache_pkg::MEM_AW-1:0];

    // Four words of the aligned line
    always_comb begin
        for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
            mem.rdata[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] =
                mem_q[{word_idx[cache_pkg::MEM_AW-1:cache_pkg::OFF_W],
                       i[cache_pkg::OFF_W-1:0]}];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= cache_pkg::LAT_W'(cache_pkg::MEM_LATENCY - 1);
        end else if (ack) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= mem.addr;
            size_q  <= mem.size;
            wr_q    <= mem.wr;
            wdata_q <= mem.wdata;
        end
        // Stores land in the ack cycle
        if (ack && wr_q) begin
            if (size_q == cache_pkg::SIZE_LINE) begin
                for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
                    mem_q[{word_idx[cache_pkg::MEM_AW-1:cache_pkg::OFF_W],
                           i[cache_pkg::OFF_W-1:0]}]
                        <= wdata_q[i*cache_pkg::WORD_W +: cache_pkg::WORD_W];
                end
            end else begin
                mem_q[word_idx] <= wdata_q[cache_pkg::WORD_W-1:0];
            end
        end
    end

endmodule

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_read,
    input  logic                          i_write,
    input  logic [cache_pkg::ADDR_W-1:0]  i_addr,
    input  logic [cache_pkg::WORD_W-1:0]  i_wdata,
    output logic                          o_ready,
    output logic                          o_done,
    output logic                          o_hit,
    output logic [cache_pkg::WORD_W-1:0]  o_rdata,
    mem_if.ctrl                           mem,
    output logic [cache_pkg::ADDR_W-1:0]  o_lookup_addr,
    input  logic                          i_hit,
    input  logic                          i_hit_way,
    input  logic [cache_pkg::LINE_W-1:0]  i_hit_line,
    input  logic                          i_victim_way,
    output logic                          o_fill,
    output logic                          o_fill_way,
    output logic [cache_pkg::TAG_W-1:0]   o_fill_tag,
    output logic [cache_pkg::LINE_W-1:0]  o_fill_line,
    output logic                          o_upd,
    output logic                          o_upd_way,
    output logic [cache_pkg::OFF_W-1:0]   o_upd_off,
    output logic [cache_pkg::WORD_W-1:0]  o_upd_word
);

    cache_pkg::ctrl_state_e         state_q;
    cache_pkg::ctrl_state_e         state_d;

    // Request captured at acceptance
    logic [cache_pkg::ADDR_W-1:0]   req_addr_q;
    logic [cache_pkg::WORD_W-1:0]   req_wdata_q;
    logic                           req_write_q;

    // Line write still waiting for its ack
    logic                           wb_pending_q;
    logic                           wb_busy;

    logic                           accept;
    logic [cache_pkg::OFF_W-1:0]    req_off;
    logic [cache_pkg::ADDR_W-1:0]   line_addr;
    logic [cache_pkg::LINE_W-1:0]   merged_line;

    logic                           issue_rd;
    logic                           issue_wr;
    cache_pkg::mem_size_e           issue_size;
    logic [cache_pkg::ADDR_W-1:0]   issue_addr;
    logic [cache_pkg::LINE_W-1:0]   issue_wdata;
    logic                           done_d;
    logic                           hit_d;
    logic [cache_pkg::WORD_W-1:0]   rdata_d;

    assign o_ready = (state_q == cache_pkg::IDLE);
    assign accept  = o_ready && (i_read || i_write);

    assign req_off   = req_addr_q[cache_pkg::OFF_W-1:0];
    assign line_addr = {req_addr_q[cache_pkg::ADDR_W-1:cache_pkg::OFF_W],
                        {cache_pkg::OFF_W{1'b0}}};

    // An ack in this cycle frees memory for a request issued now
    assign wb_busy = wb_pending_q && !mem.ack;

    // Array side
    assign o_lookup_addr = req_addr_q;
    assign o_fill_way    = i_victim_way;
    assign o_fill_tag    = req_addr_q[cache_pkg::ADDR_W-1:cache_pkg::TAG_LSB];
    assign o_fill_line   = mem.rdata;
    assign o_upd_way     = i_hit_way;
    assign o_upd_off     = req_off;
    assign o_upd_word    = req_wdata_q;

    // Hit line with the new word dropped in
    always_comb begin
        merged_line = i_hit_line;
        merged_line[req_off*cache_pkg::WORD_W +: cache_pkg::WORD_W] = req_wdata_q;
    end

    always_comb begin
        state_d     = state_q;
        issue_rd    = 1'b0;
        issue_wr    = 1'b0;
        issue_size  = cache_pkg::SIZE_LINE;
        issue_addr  = line_addr;
        issue_wdata = merged_line;
        done_d      = 1'b0;
        hit_d       = 1'b0;
        rdata_d     = i_hit_line[req_off*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        o_fill      = 1'b0;
        o_upd       = 1'b0;

        case (state_q)
            cache_pkg::IDLE: begin
                if (accept) begin
                    state_d = cache_pkg::LOOKUP;
                end
            end
            cache_pkg::LOOKUP: begin
                if (!req_write_q && i_hit) begin
                    // Read hit, allowed during an in-flight line write
                    done_d  = 1'b1;
                    hit_d   = 1'b1;
                    state_d = cache_pkg::IDLE;
                end else if (wb_busy) begin
                    state_d = cache_pkg::WAIT_WB;
                end else if (!req_write_q) begin
                    issue_rd = 1'b1;
                    state_d  = cache_pkg::MEM_READ;
                end else if (i_hit) begin
                    // Write hit: update the line and write it through
                    o_upd    = 1'b1;
                    issue_wr = 1'b1;
                    done_d   = 1'b1;
                    hit_d    = 1'b1;
                    state_d  = cache_pkg::IDLE;
                end else begin
                    // Write miss, single word, no allocate
                    issue_wr    = 1'b1;
                    issue_size  = cache_pkg::SIZE_WORD;
                    issue_addr  = req_addr_q;
                    issue_wdata = {{(cache_pkg::LINE_W-cache_pkg::WORD_W){1'b0}}, req_wdata_q};
                    state_d     = cache_pkg::MEM_WRITE;
                end
            end
            cache_pkg::WAIT_WB: begin
                // Re-run the lookup once memory is free
                if (mem.ack) begin
                    state_d = cache_pkg::LOOKUP;
                end
            end
            cache_pkg::MEM_READ: begin
                if (mem.ack) begin
                    o_fill  = 1'b1;
                    done_d  = 1'b1;
                    rdata_d = mem.rdata[req_off*cache_pkg::WORD_W +: cache_pkg::WORD_W];
                    state_d = cache_pkg::IDLE;
                end
            end
            cache_pkg::MEM_WRITE: begin
                if (mem.ack) begin
                    done_d  = 1'b1;
                    state_d = cache_pkg::IDLE;
                end
            end
            default: begin
                state_d = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q      <= cache_pkg::IDLE;
            wb_pending_q <= 1'b0;
            o_done       <= 1'b0;
            o_hit        <= 1'b0;
            mem.rd       <= 1'b0;
            mem.wr       <= 1'b0;
        end else begin
            state_q <= state_d;
            o_done  <= done_d;
            o_hit   <= hit_d;
            mem.rd  <= issue_rd;
            mem.wr  <= issue_wr;
            // New line write wins over the ack of the previous one
            if (issue_wr && (issue_size == cache_pkg::SIZE_LINE)) begin
                wb_pending_q <= 1'b1;
            end else if (mem.ack) begin
                wb_pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q  <= i_addr;
            req_wdata_q <= i_wdata;
            req_write_q <= i_write;
        end
        if (issue_rd || issue_wr) begin
            mem.addr  <= issue_addr;
            mem.size  <= issue_size;
            mem.wdata <= issue_wdata;
        end
        if (done_d) begin
            o_rdata <= rdata_d;
        end
    end

endmodule

// ==== source/cache_arrays.sv ====
`timescale 1ns/1ps

module cache_arrays (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [cache_pkg::ADDR_W-1:0]  i_lookup_addr,
    input  logic                          i_fill,
    input  logic                          i_fill_way,
    input  logic [cache_pkg::TAG_W-1:0]   i_fill_tag,
    input  logic [cache_pkg::LINE_W-1:0]  i_fill_line,
    input  logic                          i_upd,
    input  logic                          i_upd_way,
    input  logic [cache_pkg::OFF_W-1:0]   i_upd_off,
    input  logic [cache_pkg::WORD_W-1:0]  i_upd_word,
    output logic                          o_hit,
    output logic                          o_hit_way,
    output logic [cache_pkg::LINE_W-1:0]  o_hit_line,
    output logic                          o_victim_way
);

    // Per set and way storage
    logic                           valid_q [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::TAG_W-1:0]    tag_q   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::LINE_W-1:0]   line_q  [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];

    // Least recently used way of each set
    logic                           lru_q   [cache_pkg::NUM_SETS];

    logic                           idx;
    logic [cache_pkg::TAG_W-1:0]    lookup_tag;
    logic [cache_pkg::NUM_WAYS-1:0] match;
    logic                           touch;
    logic                           touch_way;

    // All updates go to the set selected by the lookup address
    assign idx        = i_lookup_addr[cache_pkg::IDX_BIT];
    assign lookup_tag = i_lookup_addr[cache_pkg::ADDR_W-1:cache_pkg::TAG_LSB];

    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            match[w] = valid_q[idx][w] && (tag_q[idx][w] == lookup_tag);
        end
    end

    assign o_hit      = |match;
    assign o_hit_way  = match[1];
    assign o_hit_line = line_q[idx][o_hit_way];

    // Invalid way 0, then invalid way 1, else the LRU way
    always_comb begin
        if (!valid_q[idx][0]) begin
            o_victim_way = 1'b0;
        end else if (!valid_q[idx][1]) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = lru_q[idx];
        end
    end

    // Fill or word update makes that way the most recent one
    assign touch     = i_fill || i_upd;
    assign touch_way = i_fill ? i_fill_way : i_upd_way;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                lru_q[s] <= 1'b0;
                for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                end
            end
        end else begin
            if (i_fill) begin
                valid_q[idx][i_fill_way] <= 1'b1;
            end
            if (touch) begin
                lru_q[idx] <= !touch_way;
            end
        end
    end

    // Tag and line payload
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[idx][i_fill_way]  <= i_fill_tag;
            line_q[idx][i_fill_way] <= i_fill_line;
        end else if (i_upd) begin
            line_q[idx][i_upd_way][i_upd_off*cache_pkg::WORD_W +: cache_pkg::WORD_W]
                <= i_upd_word;
        end
    end

endmodule

// ==== source/mem_if.sv ====
`timescale 1ns/1ps

interface mem_if;

    // Request side, one-cycle strobes
    logic                            rd;
    logic                            wr;
    logic [cache_pkg::ADDR_W-1:0]    addr;
    cache_pkg::mem_size_e            size;
    logic [cache_pkg::LINE_W-1:0]    wdata;

    // Response side
    logic [cache_pkg::LINE_W-1:0]    rdata;
    logic                            ack;

    modport ctrl (
        output rd,
        output wr,
        output addr,
        output size,
        output wdata,
        input  rdata,
        input  ack
    );

    modport mem (
        input  rd,
        input  wr,
        input  addr,
        input  size,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

// ==== source/cache_pkg.sv ====
package cache_pkg;

    // Data and address widths
    localparam int WORD_W         = 16;
    localparam int ADDR_W         = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

    // Address split: tag | set index | word offset
    localparam int TAG_LSB = 3;
    localparam int TAG_W   = ADDR_W - TAG_LSB;
    localparam int IDX_BIT = 2;
    localparam int OFF_W   = 2;

    localparam int NUM_SETS = 2;
    localparam int NUM_WAYS = 2;

    // Backing memory
    localparam int MEM_WORDS   = 1024;
    localparam int MEM_AW      = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 4;
    localparam int LAT_W       = $clog2(MEM_LATENCY);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_READ,
        MEM_WRITE,
        WAIT_WB
    } ctrl_state_e;

    typedef enum logic {
        SIZE_WORD,
        SIZE_LINE
    } mem_size_e;

endpackage
